//--- usb_rx_consts.svh
`ifndef USB_RX_CONSTS_SVH
`define USB_RX_CONSTS_SVH

// Packet identifiers as they appear on the byte stream.
`define USB_PID_SYNC    8'h0F
`define USB_PID_ACK     8'h2D
`define USB_PID_NAK     8'hA5
`define USB_PID_STL     8'hE1
`define USB_PID_STAT    8'hD2
`define USB_PID_DATA0   8'h96
`define USB_PID_DATA1   8'h5A

// Upper nibble of the status head byte.
`define USB_HEAD_DTYPE  4'h1
`define USB_HEAD_DTEMP  4'h9
`define USB_HEAD_DLINK  4'hD

// Packet type codes reported to the host.
`define USB_PKT_NONE    4'd0
`define USB_PKT_ACK     4'd1
`define USB_PKT_NAK     4'd2
`define USB_PKT_STL     4'd3
`define USB_PKT_STAT    4'd4
`define USB_PKT_DLINK   4'd8
`define USB_PKT_DTYPE   4'd9
`define USB_PKT_DTEMP   4'd10
`define USB_PKT_DATA0   4'd13
`define USB_PKT_DATA1   4'd14
`define USB_PKT_ERROR   4'd15

`define USB_CRC5_POLY   5'h05     // x^5 + x^2 + 1
`define USB_CRC5_INIT   5'h1F
`define USB_CRC16_POLY  16'h8005  // x^16 + x^15 + x^2 + 1
`define USB_CRC16_INIT  16'hFFFF

`define USB_RAM_AW      12

`endif

//--- usb_rx_pkg.sv
`include "usb_rx_consts.svh"

package usb_rx_pkg;

    typedef logic [7:0]             byte_t;
    typedef logic [3:0]             nibble_t;
    typedef logic [`USB_RAM_AW-1:0] ram_addr_t;
    typedef logic [3:0]             pkt_type_t;
    typedef logic [4:0]             crc5_t;
    typedef logic [15:0]            crc16_t;

    // One state per received byte, plus the framing states around a packet.
    typedef enum logic [4:0] {
        ST_WAIT,
        ST_PID,
        ST_SNUM0,
        ST_SNUM1,
        ST_SHEAD,
        ST_SVAL,
        ST_CRC5,
        ST_DLEN0,
        ST_DLEN1,
        ST_DHEAD,
        ST_DINFO,
        ST_PAYLOAD,
        ST_CRC16H,
        ST_CRC16L,
        ST_ERROR,
        ST_REST,
        ST_DONE
    } rx_state_t;

    typedef struct packed {
        byte_t   device_temp;
        byte_t   device_type;
        nibble_t device_stat;
        nibble_t device_idx;
        nibble_t data_idx;
    } cache_stat_t;

    typedef struct packed {
        logic      en;
        ram_addr_t addr;
        byte_t     data;
    } ram_wr_t;

endpackage

//--- crc5_byte.sv
`timescale 1ns/1ps
`include "usb_rx_consts.svh"

module crc5_byte (
    input  logic              clk,
    input  logic              rst,
    input  logic              clr,
    input  logic              en,
    input  usb_rx_pkg::byte_t din,
    output usb_rx_pkg::crc5_t crc
);
    import usb_rx_pkg::*;

    crc5_t crc_next;

    // Eight serial steps folded into one cycle, MSB of the byte first.
    always_comb begin
        crc_next = crc;
        for (int i = 7; i >= 0; i--) begin
            if (crc_next[4] ^ din[i]) begin
                crc_next = {crc_next[3:0], 1'b0} ^ `USB_CRC5_POLY;
            end else begin
                crc_next = {crc_next[3:0], 1'b0};
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            crc <= `USB_CRC5_INIT;
        end else if (clr) begin
            crc <= `USB_CRC5_INIT;  // A new packet restarts from the seed.
        end else if (en) begin
            crc <= crc_next;
        end
    end

endmodule

//--- crc16_byte.sv
`timescale 1ns/1ps
`include "usb_rx_consts.svh"

module crc16_byte (
    input  logic               clk,
    input  logic               rst,
    input  logic               clr,
    input  logic               en,
    input  usb_rx_pkg::byte_t  din,
    output usb_rx_pkg::crc16_t crc
);
    import usb_rx_pkg::*;

    crc16_t crc_next;

    // Same bit-serial update as the CRC5 unit, unrolled over the byte.
    always_comb begin
        crc_next = crc;
        for (int i = 7; i >= 0; i--) begin
            if (crc_next[15] ^ din[i]) begin
                crc_next = {crc_next[14:0], 1'b0} ^ `USB_CRC16_POLY;
            end else begin
                crc_next = {crc_next[14:0], 1'b0};
            end
        end
    end

    // The register holds its value while disabled, so the receiver can
    // compare both CRC bytes against the same result.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            crc <= `USB_CRC16_INIT;
        end else if (clr) begin
            crc <= `USB_CRC16_INIT;
        end else if (en) begin
            crc <= crc_next;
        end
    end

endmodule

//--- rx_packet_ram.sv
`timescale 1ns/1ps
`include "usb_rx_consts.svh"

module rx_packet_ram (
    input  logic                  clk,
    input  usb_rx_pkg::ram_wr_t   wr,
    input  usb_rx_pkg::ram_addr_t rd_addr,
    output usb_rx_pkg::byte_t     rd_data
);
    import usb_rx_pkg::*;

    localparam int DEPTH = 1 << `USB_RAM_AW;

    byte_t mem [DEPTH];

    // Write port, driven by the receiver while it is in the payload state.
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // Host read port with one cycle of latency.
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];  // Same-address collision returns the old byte.
    end

endmodule

//--- usb_rx.sv
`timescale 1ns/1ps
`include "usb_rx_consts.svh"

module usb_rx (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    fire,
    input  usb_rx_pkg::byte_t       rx_data,
    input  logic                    fd,
    input  usb_rx_pkg::ram_addr_t   ram_base,
    input  usb_rx_pkg::crc5_t       crc5,
    input  usb_rx_pkg::crc16_t      crc16,
    output logic                    fs,
    output usb_rx_pkg::pkt_type_t   pkt_type,
    output usb_rx_pkg::cache_stat_t cache_stat,
    output usb_rx_pkg::ram_wr_t     ram_wr,
    output logic                    crc_clr,
    output logic                    crc_en
);
    import usb_rx_pkg::*;

    rx_state_t state;
    rx_state_t state_next;
    pkt_type_t pid_type;
    nibble_t   len_hi;
    ram_addr_t data_len;
    ram_addr_t pay_cnt;
    logic      last_byte;
    logic      crc5_ok;
    logic      crc16_hi_ok;
    logic      crc16_lo_ok;

    // Packet type implied by the PID byte alone.
    always_comb begin
        case (rx_data)
            `USB_PID_ACK:   pid_type = `USB_PKT_ACK;
            `USB_PID_NAK:   pid_type = `USB_PKT_NAK;
            `USB_PID_STL:   pid_type = `USB_PKT_STL;
            `USB_PID_STAT:  pid_type = `USB_PKT_STAT;
            `USB_PID_DATA0: pid_type = `USB_PKT_DATA0;
            `USB_PID_DATA1: pid_type = `USB_PKT_DATA1;
            default:        pid_type = `USB_PKT_ERROR;
        endcase
    end

    assign last_byte   = (pay_cnt == data_len - 1'b1);
    assign crc5_ok     = (rx_data == {3'b000, crc5});
    assign crc16_hi_ok = (rx_data == crc16[15:8]);
    assign crc16_lo_ok = (rx_data == crc16[7:0]);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_WAIT;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ST_WAIT: begin
                if (fire && rx_data == `USB_PID_SYNC) begin
                    state_next = ST_PID;
                end
            end
            ST_PID: begin
                case (pid_type)
                    `USB_PKT_ACK,
                    `USB_PKT_NAK,
                    `USB_PKT_STL:   state_next = ST_REST;  // Handshakes end at the PID.
                    `USB_PKT_STAT:  state_next = ST_SNUM0;
                    `USB_PKT_DATA0,
                    `USB_PKT_DATA1: state_next = ST_DLEN0;
                    default:        state_next = ST_ERROR;
                endcase
            end
            ST_SNUM0:   state_next = ST_SNUM1;
            ST_SNUM1:   state_next = ST_SHEAD;
            ST_SHEAD:   state_next = ST_SVAL;
            ST_SVAL:    state_next = ST_CRC5;
            ST_CRC5:    state_next = crc5_ok ? ST_REST : ST_ERROR;
            ST_DLEN0:   state_next = ST_DLEN1;
            ST_DLEN1:   state_next = ST_DHEAD;
            ST_DHEAD:   state_next = ST_DINFO;
            ST_DINFO:   state_next = ST_PAYLOAD;
            ST_PAYLOAD: begin
                if (last_byte) begin
                    state_next = ST_CRC16H;
                end
            end
            ST_CRC16H:  state_next = crc16_hi_ok ? ST_CRC16L : ST_ERROR;
            ST_CRC16L:  state_next = crc16_lo_ok ? ST_REST : ST_ERROR;
            ST_ERROR:   state_next = ST_REST;
            ST_REST: begin
                if (!fire) begin
                    state_next = ST_DONE;  // Drain the stream before reporting.
                end
            end
            ST_DONE: begin
                if (fd) begin
                    state_next = ST_WAIT;
                end
            end
            default:    state_next = ST_WAIT;
        endcase
    end

    // The PID gives a first type; the status head or an error refines it.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pkt_type <= `USB_PKT_NONE;
        end else begin
            case (state)
                ST_PID:   pkt_type <= pid_type;
                ST_SHEAD: begin
                    case (rx_data[7:4])
                        `USB_HEAD_DLINK: pkt_type <= `USB_PKT_DLINK;
                        `USB_HEAD_DTYPE: pkt_type <= `USB_PKT_DTYPE;
                        `USB_HEAD_DTEMP: pkt_type <= `USB_PKT_DTEMP;
                        default:         pkt_type <= `USB_PKT_STAT;
                    endcase
                end
                ST_ERROR: pkt_type <= `USB_PKT_ERROR;
                default:  pkt_type <= pkt_type;
            endcase
        end
    end

    // Device status cache. Fields keep their new values even if the CRC
    // check later fails.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cache_stat <= '0;
        end else begin
            case (state)
                ST_SHEAD: cache_stat.device_idx <= rx_data[3:0];
                ST_SVAL: begin
                    if (pkt_type == `USB_PKT_DTYPE) begin
                        cache_stat.device_type <= rx_data;
                    end else if (pkt_type == `USB_PKT_DTEMP) begin
                        cache_stat.device_temp <= rx_data;
                    end
                end
                ST_DHEAD: cache_stat.device_idx <= rx_data[3:0];
                ST_DINFO: begin
                    cache_stat.data_idx    <= rx_data[7:4];
                    cache_stat.device_stat <= rx_data[3:0];
                end
                default:  cache_stat <= cache_stat;
            endcase
        end
    end

    // Payload length N, loaded from the two length bytes.
    always_ff @(posedge clk) begin
        if (state == ST_DLEN0) begin
            len_hi <= rx_data[3:0];
        end
        if (state == ST_DLEN1) begin
            data_len <= {len_hi, rx_data};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pay_cnt <= '0;
        end else if (state == ST_PAYLOAD) begin
            pay_cnt <= pay_cnt + 1'b1;
        end else begin
            pay_cnt <= '0;
        end
    end

    assign fs      = (state == ST_DONE);
    assign crc_clr = (state == ST_PID);

    // Every byte between the PID and the CRC bytes feeds both CRC units.
    assign crc_en = state inside {ST_SNUM0, ST_SNUM1, ST_SHEAD, ST_SVAL,
                                  ST_DLEN0, ST_DLEN1, ST_DHEAD, ST_DINFO, ST_PAYLOAD};

    assign ram_wr.en   = (state == ST_PAYLOAD);
    assign ram_wr.addr = ram_base + pay_cnt;
    assign ram_wr.data = rx_data;  // Written on the edge that consumes it.

endmodule

//--- usb_rx_top.sv
`timescale 1ns/1ps

module usb_rx_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    fire,
    input  usb_rx_pkg::byte_t       rx_data,
    input  logic                    fd,
    input  usb_rx_pkg::ram_addr_t   ram_base,
    input  usb_rx_pkg::ram_addr_t   rd_addr,
    output logic                    fs,
    output usb_rx_pkg::pkt_type_t   pkt_type,
    output usb_rx_pkg::cache_stat_t cache_stat,
    output usb_rx_pkg::byte_t       rd_data
);
    import usb_rx_pkg::*;

    crc5_t   crc5;
    crc16_t  crc16;
    ram_wr_t ram_wr;
    logic    crc_clr;
    logic    crc_en;

    usb_rx i_rx (
        .clk        (clk),
        .rst        (rst),
        .fire       (fire),
        .rx_data    (rx_data),
        .fd         (fd),
        .ram_base   (ram_base),
        .crc5       (crc5),
        .crc16      (crc16),
        .fs         (fs),
        .pkt_type   (pkt_type),
        .cache_stat (cache_stat),
        .ram_wr     (ram_wr),
        .crc_clr    (crc_clr),
        .crc_en     (crc_en)
    );

    // Both CRC units see the raw stream byte.
    crc5_byte i_crc5 (
        .clk (clk),
        .rst (rst),
        .clr (crc_clr),
        .en  (crc_en),
        .din (rx_data),
        .crc (crc5)
    );

    crc16_byte i_crc16 (
        .clk (clk),
        .rst (rst),
        .clr (crc_clr),
        .en  (crc_en),
        .din (rx_data),
        .crc (crc16)
    );

    rx_packet_ram i_ram (
        .clk     (clk),
        .wr      (ram_wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

//--- tb_usb_rx.sv
`timescale 1ns/1ps
`include "usb_rx_consts.svh"

module tb_usb_rx;
    import usb_rx_pkg::*;

    logic        clk;
    logic        rst;
    logic        fire;
    byte_t       rx_data;
    logic        fd;
    ram_addr_t   ram_base;
    ram_addr_t   rd_addr;
    logic        fs;
    pkt_type_t   pkt_type;
    cache_stat_t cache_stat;
    byte_t       rd_data;

    byte_t       tx_q[$];   // Bytes of the next packet, sync byte first.
    byte_t       pay_q[$];
    cache_stat_t exp_cache;
    logic [31:0] lcg_state  = 32'd69309;
    int          err_count  = 0;
    int          fail_count = 0;

    usb_rx_top i_dut (
        .clk        (clk),
        .rst        (rst),
        .fire       (fire),
        .rx_data    (rx_data),
        .fd         (fd),
        .ram_base   (ram_base),
        .rd_addr    (rd_addr),
        .fs         (fs),
        .pkt_type   (pkt_type),
        .cache_stat (cache_stat),
        .rd_data    (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Inputs change and outputs are sampled 5 ns after the rising edge.
    task automatic step();
        @(posedge clk);
        #5;
    endtask

    function automatic byte_t lcg_byte();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    // CRCs over tx_q from index first to the end, MSB of each byte first.
    function automatic crc5_t ref_crc5(input int first);
        crc5_t c;
        logic  fb;
        c = `USB_CRC5_INIT;
        for (int k = first; k < tx_q.size(); k++) begin
            for (int j = 7; j >= 0; j--) begin
                fb = c[4] ^ tx_q[k][j];
                c  = {c[3:0], 1'b0};
                if (fb) begin
                    c = c ^ `USB_CRC5_POLY;
                end
            end
        end
        return c;
    endfunction

    function automatic crc16_t ref_crc16(input int first);
        crc16_t c;
        logic   fb;
        c = `USB_CRC16_INIT;
        for (int k = first; k < tx_q.size(); k++) begin
            for (int j = 7; j >= 0; j--) begin
                fb = c[15] ^ tx_q[k][j];
                c  = {c[14:0], 1'b0};
                if (fb) begin
                    c = c ^ `USB_CRC16_POLY;
                end
            end
        end
        return c;
    endfunction

    task automatic check_pkt_type(input pkt_type_t exp);
        if (pkt_type !== exp) begin
            $display("ERROR pkt_type: got 0x%h, expected 0x%h", pkt_type, exp);
            err_count++;
        end
    endtask

    task automatic check_cache(input cache_stat_t exp);
        if (cache_stat !== exp) begin
            $display("ERROR cache_stat: got 0x%h, expected 0x%h", cache_stat, exp);
            err_count++;
        end
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic send_packet();
        foreach (tx_q[k]) begin
            rx_data = tx_q[k];
            fire    = 1'b1;
            step();
        end
        fire    = 1'b0;
        rx_data = 8'h00;
    endtask

    task automatic wait_fs();
        int n;
        n = 0;
        while (fs !== 1'b1 && n < 200) begin
            step();
            n++;
        end
        if (fs !== 1'b1) begin
            $display("Timeout waiting 200 cycles for fs to rise");
            fail_count++;
        end
    endtask

    task automatic ack_fs();
        int n;
        fd = 1'b1;
        step();
        fd = 1'b0;
        n  = 0;
        while (fs !== 1'b0 && n < 4) begin
            step();
            n++;
        end
        if (fs !== 1'b0) begin
            $display("fs still high 4 cycles after the fd pulse");
            fail_count++;
        end
    endtask

    task automatic expect_result(input pkt_type_t exp_type);
        wait_fs();
        check_pkt_type(exp_type);
        check_cache(exp_cache);
        ack_fs();
    endtask

    task automatic handshake_packet(input byte_t pid, input pkt_type_t exp_type);
        tx_q = {`USB_PID_SYNC, pid};
        send_packet();
        expect_result(exp_type);
    endtask

    task automatic status_packet(input nibble_t code, input nibble_t idx, input logic bad_crc);
        byte_t     value;
        byte_t     crc_byte;
        pkt_type_t exp_type;
        tx_q = {`USB_PID_SYNC, `USB_PID_STAT};
        tx_q.push_back(lcg_byte());
        tx_q.push_back(lcg_byte());
        tx_q.push_back({code, idx});
        value = lcg_byte();
        tx_q.push_back(value);
        crc_byte = {3'b000, ref_crc5(2)};
        if (bad_crc) begin
            crc_byte = crc_byte ^ 8'h01;
        end
        tx_q.push_back(crc_byte);
        exp_cache.device_idx = idx;  // Cache fields change even on a CRC error.
        case (code)
            `USB_HEAD_DTYPE: begin
                exp_cache.device_type = value;
                exp_type = `USB_PKT_DTYPE;
            end
            `USB_HEAD_DTEMP: begin
                exp_cache.device_temp = value;
                exp_type = `USB_PKT_DTEMP;
            end
            `USB_HEAD_DLINK: exp_type = `USB_PKT_DLINK;
            default:         exp_type = `USB_PKT_STAT;
        endcase
        if (bad_crc) begin
            exp_type = `USB_PKT_ERROR;
        end
        send_packet();
        expect_result(exp_type);
    endtask

    task automatic data_packet(input byte_t pid, input int n, input ram_addr_t base,
                               input logic bad_crc);
        ram_addr_t len;
        byte_t     head;
        byte_t     info;
        crc16_t    crc;
        pkt_type_t exp_type;
        len      = ram_addr_t'(n);
        head     = lcg_byte();
        info     = lcg_byte();
        ram_base = base;
        pay_q.delete();
        tx_q = {`USB_PID_SYNC, pid, byte_t'({4'h0, len[11:8]}), len[7:0], head, info};
        for (int k = 0; k < n; k++) begin
            pay_q.push_back(lcg_byte());
            tx_q.push_back(pay_q[k]);
        end
        crc = ref_crc16(2);
        if (bad_crc) begin
            crc[7:0] = crc[7:0] ^ 8'h01;
        end
        tx_q.push_back(crc[15:8]);
        tx_q.push_back(crc[7:0]);
        exp_cache.device_idx  = head[3:0];
        exp_cache.data_idx    = info[7:4];
        exp_cache.device_stat = info[3:0];
        exp_type = (pid == `USB_PID_DATA0) ? `USB_PKT_DATA0 : `USB_PKT_DATA1;
        if (bad_crc) begin
            exp_type = `USB_PKT_ERROR;
        end
        send_packet();
        expect_result(exp_type);
        // The payload is in RAM whatever the CRC said.
        for (int k = 0; k < n; k++) begin
            rd_addr = base + ram_addr_t'(k);
            step();
            check_byte($sformatf("rd_data[0x%h]", rd_addr), rd_data, pay_q[k]);
        end
    endtask

    task automatic done_held_without_fd();
        int drops;
        drops = 0;
        tx_q  = {`USB_PID_SYNC, `USB_PID_ACK};
        send_packet();
        wait_fs();
        check_pkt_type(`USB_PKT_ACK);
        tx_q = {`USB_PID_SYNC, `USB_PID_STL};  // Arrives while fs is still high.
        send_packet();
        for (int k = 0; k < 10; k++) begin
            if (fs !== 1'b1) begin
                drops++;
            end
            step();
        end
        if (drops != 0) begin
            $display("fs dropped in %0d of 10 cycles without fd", drops);
            fail_count++;
        end
        check_pkt_type(`USB_PKT_ACK);
        check_cache(exp_cache);
        ack_fs();
        handshake_packet(`USB_PID_NAK, `USB_PKT_NAK);
    endtask

    initial begin
        rst       = 1'b1;
        fire      = 1'b0;
        rx_data   = 8'h00;
        fd        = 1'b0;
        ram_base  = '0;
        rd_addr   = '0;
        exp_cache = '0;
        repeat (3) @(posedge clk);
        #5;
        rst = 1'b0;
        if (fs !== 1'b0) begin
            $display("fs is high right after reset");
            fail_count++;
        end
        check_pkt_type(`USB_PKT_NONE);
        check_cache(exp_cache);

        handshake_packet(`USB_PID_ACK, `USB_PKT_ACK);
        handshake_packet(`USB_PID_NAK, `USB_PKT_NAK);
        handshake_packet(`USB_PID_STL, `USB_PKT_STL);

        status_packet(`USB_HEAD_DTYPE, 4'h3, 1'b0);
        status_packet(`USB_HEAD_DTEMP, 4'h5, 1'b0);
        status_packet(`USB_HEAD_DLINK, 4'h7, 1'b0);
        status_packet(4'h4, 4'h2, 1'b0);  // Head code outside the three known ones.

        data_packet(`USB_PID_DATA0, 1, 12'h010, 1'b0);
        data_packet(`USB_PID_DATA1, 5, 12'h7F0, 1'b0);
        data_packet(`USB_PID_DATA0, 37, 12'hF00, 1'b0);

        status_packet(`USB_HEAD_DTEMP, 4'hC, 1'b1);
        data_packet(`USB_PID_DATA1, 5, 12'h300, 1'b1);

        tx_q = {`USB_PID_SYNC, 8'h77, 8'h12, 8'h34};
        send_packet();
        expect_result(`USB_PKT_ERROR);

        // Noise ahead of the sync byte, none of it equal to the sync value.
        tx_q = {8'h33, 8'hC4, 8'h00, 8'hF0, `USB_PID_SYNC, `USB_PID_NAK};
        send_packet();
        expect_result(`USB_PKT_NAK);

        done_held_without_fd();

        $display("Errors: %0d value mismatches, %0d other failures", err_count, fail_count);
        if (err_count == 0 && fail_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+.
usb_rx_pkg.sv
crc5_byte.sv
crc16_byte.sv
rx_packet_ram.sv
usb_rx.sv
usb_rx_top.sv
tb_usb_rx.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_usb_rx
FILELIST   := tb.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --timescale 1ns/1ps -Wno-fatal
LINT_FLAGS := --lint-only --timing --timescale 1ns/1ps -Wall
PASS_MSG   := test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
